/* ex_top.f */
+incdir+rtl
rtl/ex_pkg.sv
rtl/alu_lane.sv
rtl/execute_stage.sv
rtl/result_fifo.sv
rtl/writeback_unit.sv
rtl/ex_top.sv
test/ex_top_assertions.sv
test/ex_top_tb.sv

/* test/ex_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module ex_top_tb
    import ex_pkg::*;
();

    localparam int NUM_PAIRS  = 400;
    localparam int MAX_CYCLES = NUM_PAIRS * 40;
    localparam int DEPTH      = `EX_FIFO_DEPTH;

    typedef struct packed {
        logic      lane;
        reg_addr_t rd;
        data_t     data;
    } retire_t;

    logic      clk = 1'b0;
    logic      arst_n_i;
    logic      issue_valid_i;
    logic      issue_ready_o;
    alu_op_e   op0_i;
    data_t     a0_i;
    data_t     b0_i;
    reg_addr_t rd0_i;
    logic      wen0_i;
    data_t     pc0_i;
    data_t     imm0_i;
    alu_op_e   op1_i;
    data_t     a1_i;
    data_t     b1_i;
    reg_addr_t rd1_i;
    logic      wen1_i;
    logic      branch_valid_o;
    data_t     branch_target_o;
    logic      retire_valid_o;
    logic      retire_lane_o;
    reg_addr_t retire_rd_o;
    data_t     retire_data_o;
    logic      retire_ready_i;

    retire_t   exp_retire[$];
    data_t     exp_branch[$];
    logic      branch_due = 1'b0;
    logic      stall_seen = 1'b0;
    retire_t   stalled;
    int        cycle_cnt = 0;
    int        stall_left = 0;

    ex_top UUT (.*);

    always #4 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("[FAIL] %0t: %s", $time, msg));
    endtask

    task automatic check_retire(input logic exp_lane, input reg_addr_t exp_rd,
                                input data_t exp_data, input string what);
        if (retire_lane_o !== exp_lane || retire_rd_o !== exp_rd
            || retire_data_o !== exp_data) begin
            report_mismatch($sformatf(
                "%s: got lane %0d rd %0d data %h, expected lane %0d rd %0d data %h",
                what, retire_lane_o, retire_rd_o, retire_data_o,
                exp_lane, exp_rd, exp_data));
        end
    endtask

    task automatic check_branch(input data_t exp_target);
        if (branch_target_o !== exp_target) begin
            report_mismatch($sformatf("branch target %h, expected %h",
                                      branch_target_o, exp_target));
        end
    endtask

    function automatic data_t expected_result(input alu_op_e op, input data_t a, input data_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            default: return '0;
        endcase
    endfunction

    task automatic make_pair();
        op0_i  = alu_op_e'(4'($urandom_range(0, 8)));
        a0_i   = $urandom;
        // equal operands often so that branches go both ways
        b0_i   = ($urandom_range(0, 2) == 0) ? a0_i : data_t'($urandom);
        rd0_i  = reg_addr_t'($urandom);
        wen0_i = ($urandom_range(0, 3) != 0);
        pc0_i  = data_t'($urandom) & ~data_t'(3);
        imm0_i = $urandom;
        op1_i  = alu_op_e'(4'($urandom_range(0, 8)));
        a1_i   = $urandom;
        b1_i   = $urandom;
        rd1_i  = reg_addr_t'($urandom);
        wen1_i = ($urandom_range(0, 3) != 0);
    endtask

    task automatic pick_retire_ready();
        if (stall_left > 0) begin
            retire_ready_i = 1'b0;
            stall_left--;
        end else if ($urandom_range(0, 15) == 0) begin
            // long stall that fills the buffer
            stall_left     = $urandom_range(4, 30);
            retire_ready_i = 1'b0;
        end else begin
            retire_ready_i = ($urandom_range(0, 3) != 0);
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            abort_run($sformatf("timeout: run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    // sample mid-cycle where inputs and outputs have settled
    always @(negedge clk) begin : monitor
        retire_t exp_item;
        logic    taken;
        logic    is_br0;
        logic    is_br1;
        if (arst_n_i) begin
            if (UUT.u_assertions.fail_cnt != 0) begin
                abort_run("a bound assertion failed, see the error above");
            end
            if (branch_valid_o !== branch_due) begin
                report_mismatch($sformatf("branch_valid_o is %b, expected %b",
                                          branch_valid_o, branch_due));
            end
            if (branch_due) begin
                check_branch(exp_branch.pop_front());
            end
            if (stall_seen) begin
                if (!retire_valid_o) begin
                    report_mismatch("retire_valid_o dropped while stalled");
                end
                check_retire(stalled.lane, stalled.rd, stalled.data, "stalled retire changed");
            end
            if (retire_valid_o && retire_ready_i) begin
                if (exp_retire.size() == 0) begin
                    report_mismatch("retirement while none expected");
                end else begin
                    exp_item = exp_retire.pop_front();
                    check_retire(exp_item.lane, exp_item.rd, exp_item.data, "retire");
                end
            end
            stall_seen = retire_valid_o && !retire_ready_i;
            stalled    = {retire_lane_o, retire_rd_o, retire_data_o};
            branch_due = 1'b0;
            if (issue_valid_i && issue_ready_o) begin
                is_br0 = (op0_i == OP_BEQ) || (op0_i == OP_BNE);
                is_br1 = (op1_i == OP_BEQ) || (op1_i == OP_BNE);
                taken  = ((op0_i == OP_BEQ) && (a0_i == b0_i))
                      || ((op0_i == OP_BNE) && (a0_i != b0_i));
                if (wen0_i && !is_br0) begin
                    exp_retire.push_back({1'b0, rd0_i, expected_result(op0_i, a0_i, b0_i)});
                end
                // taken main branch squashes the deputy write
                if (wen1_i && !is_br1 && !taken) begin
                    exp_retire.push_back({1'b1, rd1_i, expected_result(op1_i, a1_i, b1_i)});
                end
                if (taken) begin
                    exp_branch.push_back(pc0_i + imm0_i);
                end
                branch_due = taken;
            end
        end
    end

    initial begin
        int   sent;
        int   stalled_accepts;
        logic took;
        void'($urandom(32'ha62e_5fb7));
        arst_n_i       = 1'b0;
        issue_valid_i  = 1'b0;
        retire_ready_i = 1'b0;
        op0_i  = OP_ADD;
        a0_i   = '0;
        b0_i   = '0;
        rd0_i  = '0;
        wen0_i = 1'b0;
        pc0_i  = '0;
        imm0_i = '0;
        op1_i  = OP_ADD;
        a1_i   = '0;
        b1_i   = '0;
        rd1_i  = '0;
        wen1_i = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        @(negedge clk);
        if (!issue_ready_o || branch_valid_o || retire_valid_o) begin
            report_mismatch("wrong issue_ready_o, branch_valid_o or retire_valid_o after reset");
        end
        @(posedge clk);
        #1;

        // retire port blocked, buffer and writeback fill up
        stalled_accepts = 0;
        took            = 1'b1;
        issue_valid_i   = 1'b1;
        repeat (3 * DEPTH + 8) begin
            if (took) begin
                make_pair();
                op0_i  = OP_ADD;
                wen0_i = 1'b1;
            end
            @(negedge clk);
            took = issue_ready_o;
            if (took) begin
                stalled_accepts++;
            end
            @(posedge clk);
            #1;
        end
        if (stalled_accepts > DEPTH + 1 || issue_ready_o) begin
            report_mismatch($sformatf("%0d pairs accepted under stall, issue_ready_o %b",
                                      stalled_accepts, issue_ready_o));
        end

        sent = 0;
        while (sent < NUM_PAIRS) begin
            if (!issue_valid_i && $urandom_range(0, 3) != 0) begin
                make_pair();
                issue_valid_i = 1'b1;
            end
            pick_retire_ready();
            @(negedge clk);
            took = issue_valid_i && issue_ready_o;
            if (took) begin
                sent++;
            end
            @(posedge clk);
            #1;
            if (took) begin
                issue_valid_i = 1'b0;
            end
        end

        issue_valid_i  = 1'b0;
        retire_ready_i = 1'b1;
        while (exp_retire.size() != 0 || branch_due) begin
            @(posedge clk);
        end
        // margin for any stray retirement
        repeat (2 * DEPTH + 4) @(posedge clk);
        if (exp_retire.size() != 0 || exp_branch.size() != 0) begin
            abort_run("expected results were still outstanding at the end of the run");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* test/ex_top_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module ex_top_assertions
    import ex_pkg::*;
(
    input logic                            clk,
    input logic                            arst_n_i,
    input logic [$clog2(`EX_FIFO_DEPTH):0] credit_cnt_i,
    input logic [$clog2(`EX_FIFO_DEPTH):0] fifo_count_i,
    input logic                            push_valid_i,
    input logic                            issue_valid_i,
    input logic                            issue_ready_i,
    input logic                            branch_valid_i,
    input logic                            retire_valid_i,
    input logic                            retire_ready_i,
    input logic                            retire_lane_i,
    input reg_addr_t                       retire_rd_i,
    input data_t                           retire_data_i
);

    int fail_cnt = 0;

    credit_bound: assert property (@(posedge clk) disable iff (!arst_n_i)
        credit_cnt_i <= `EX_FIFO_DEPTH)
        else begin
            $error("credit count above buffer depth");
            fail_cnt = fail_cnt + 1;
        end

    no_push_when_full: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(push_valid_i && (fifo_count_i == `EX_FIFO_DEPTH)))
        else begin
            $error("push into a full result buffer");
            fail_cnt = fail_cnt + 1;
        end

    // stalled retirement must not move
    retire_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        (retire_valid_i && !retire_ready_i) |=>
            (retire_valid_i && $stable(retire_lane_i)
             && $stable(retire_rd_i) && $stable(retire_data_i)))
        else begin
            $error("retire outputs changed while stalled");
            fail_cnt = fail_cnt + 1;
        end

    // one branch pulse per accepted pair
    branch_after_accept: assert property (@(posedge clk) disable iff (!arst_n_i)
        branch_valid_i |-> $past(issue_valid_i && issue_ready_i))
        else begin
            $error("branch_valid_o without an accepted pair one cycle before");
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind ex_top ex_top_assertions u_assertions (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .credit_cnt_i  (u_execute.credit_cnt),
    .fifo_count_i  (u_result_fifo.count),
    .push_valid_i  (push_valid),
    .issue_valid_i (issue_valid_i),
    .issue_ready_i (issue_ready_o),
    .branch_valid_i(branch_valid_o),
    .retire_valid_i(retire_valid_o),
    .retire_ready_i(retire_ready_i),
    .retire_lane_i (retire_lane_o),
    .retire_rd_i   (retire_rd_o),
    .retire_data_i (retire_data_o)
);

`default_nettype wire

/* rtl/ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_top
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,

    input  logic      issue_valid_i,
    output logic      issue_ready_o,
    input  alu_op_e   op0_i,
    input  data_t     a0_i,
    input  data_t     b0_i,
    input  reg_addr_t rd0_i,
    input  logic      wen0_i,
    input  data_t     pc0_i,
    input  data_t     imm0_i,
    input  alu_op_e   op1_i,
    input  data_t     a1_i,
    input  data_t     b1_i,
    input  reg_addr_t rd1_i,
    input  logic      wen1_i,

    output logic      branch_valid_o,
    output data_t     branch_target_o,

    output logic      retire_valid_o,
    output logic      retire_lane_o,
    output reg_addr_t retire_rd_o,
    output data_t     retire_data_o,
    input  logic      retire_ready_i
);

    logic      push_valid;
    logic      push_wen0;
    reg_addr_t push_rd0;
    data_t     push_data0;
    logic      push_wen1;
    reg_addr_t push_rd1;
    data_t     push_data1;
    logic      credit_return;

    logic      not_empty;
    logic      pop;
    logic      head_wen0;
    reg_addr_t head_rd0;
    data_t     head_data0;
    logic      head_wen1;
    reg_addr_t head_rd1;
    data_t     head_data1;

    execute_stage u_execute (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .issue_valid_i  (issue_valid_i),
        .issue_ready_o  (issue_ready_o),
        .op0_i          (op0_i),
        .a0_i           (a0_i),
        .b0_i           (b0_i),
        .rd0_i          (rd0_i),
        .wen0_i         (wen0_i),
        .pc0_i          (pc0_i),
        .imm0_i         (imm0_i),
        .op1_i          (op1_i),
        .a1_i           (a1_i),
        .b1_i           (b1_i),
        .rd1_i          (rd1_i),
        .wen1_i         (wen1_i),
        .credit_return_i(credit_return),
        .push_valid_o   (push_valid),
        .push_wen0_o    (push_wen0),
        .push_rd0_o     (push_rd0),
        .push_data0_o   (push_data0),
        .push_wen1_o    (push_wen1),
        .push_rd1_o     (push_rd1),
        .push_data1_o   (push_data1),
        .branch_valid_o (branch_valid_o),
        .branch_target_o(branch_target_o)
    );

    result_fifo u_result_fifo (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .push_i         (push_valid),
        .wen0_i         (push_wen0),
        .rd0_i          (push_rd0),
        .data0_i        (push_data0),
        .wen1_i         (push_wen1),
        .rd1_i          (push_rd1),
        .data1_i        (push_data1),
        .pop_i          (pop),
        .not_empty_o    (not_empty),
        .head_wen0_o    (head_wen0),
        .head_rd0_o     (head_rd0),
        .head_data0_o   (head_data0),
        .head_wen1_o    (head_wen1),
        .head_rd1_o     (head_rd1),
        .head_data1_o   (head_data1),
        .credit_return_o(credit_return)
    );

    writeback_unit u_writeback (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .not_empty_i   (not_empty),
        .head_wen0_i   (head_wen0),
        .head_rd0_i    (head_rd0),
        .head_data0_i  (head_data0),
        .head_wen1_i   (head_wen1),
        .head_rd1_i    (head_rd1),
        .head_data1_i  (head_data1),
        .pop_o         (pop),
        .retire_valid_o(retire_valid_o),
        .retire_lane_o (retire_lane_o),
        .retire_rd_o   (retire_rd_o),
        .retire_data_o (retire_data_o),
        .retire_ready_i(retire_ready_i)
    );

endmodule

`default_nettype wire

/* rtl/writeback_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_unit
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,

    input  logic      not_empty_i,
    input  logic      head_wen0_i,
    input  reg_addr_t head_rd0_i,
    input  data_t     head_data0_i,
    input  logic      head_wen1_i,
    input  reg_addr_t head_rd1_i,
    input  data_t     head_data1_i,
    output logic      pop_o,

    output logic      retire_valid_o,
    output logic      retire_lane_o,
    output reg_addr_t retire_rd_o,
    output data_t     retire_data_o,
    input  logic      retire_ready_i
);

    wb_state_e state;
    wb_state_e state_next;
    logic      hold_wen1;
    reg_addr_t hold_rd0;
    reg_addr_t hold_rd1;
    data_t     hold_data0;
    data_t     hold_data1;

    assign pop_o = (state == WB_EMPTY) && not_empty_i;

    always_comb begin
        state_next = state;
        case (state)
            WB_EMPTY: begin
                // pairs without writes fall straight through
                if (not_empty_i) begin
                    if (head_wen0_i) begin
                        state_next = WB_LANE0;
                    end else if (head_wen1_i) begin
                        state_next = WB_LANE1;
                    end
                end
            end
            WB_LANE0: begin
                if (retire_ready_i) begin
                    state_next = hold_wen1 ? WB_LANE1 : WB_EMPTY;
                end
            end
            WB_LANE1: begin
                if (retire_ready_i) begin
                    state_next = WB_EMPTY;
                end
            end
            default: state_next = WB_EMPTY;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state <= WB_EMPTY;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            hold_wen1  <= head_wen1_i;
            hold_rd0   <= head_rd0_i;
            hold_rd1   <= head_rd1_i;
            hold_data0 <= head_data0_i;
            hold_data1 <= head_data1_i;
        end
    end

    // outputs come from held state only, so they stay put while stalled
    assign retire_valid_o = (state == WB_LANE0) || (state == WB_LANE1);
    assign retire_lane_o  = (state == WB_LANE1);
    assign retire_rd_o    = retire_lane_o ? hold_rd1 : hold_rd0;
    assign retire_data_o  = retire_lane_o ? hold_data1 : hold_data0;

endmodule

`default_nettype wire

/* rtl/result_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module result_fifo
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,

    input  logic      push_i,
    input  logic      wen0_i,
    input  reg_addr_t rd0_i,
    input  data_t     data0_i,
    input  logic      wen1_i,
    input  reg_addr_t rd1_i,
    input  data_t     data1_i,

    input  logic      pop_i,
    output logic      not_empty_o,
    output logic      head_wen0_o,
    output reg_addr_t head_rd0_o,
    output data_t     head_data0_o,
    output logic      head_wen1_o,
    output reg_addr_t head_rd1_o,
    output data_t     head_data1_o,

    output logic      credit_return_o
);

    localparam int DEPTH = `EX_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic      wen0_mem [DEPTH];
    reg_addr_t rd0_mem  [DEPTH];
    data_t     data0_mem[DEPTH];
    logic      wen1_mem [DEPTH];
    reg_addr_t rd1_mem  [DEPTH];
    data_t     data1_mem[DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    always_ff @(posedge clk) begin
        if (push_i) begin
            wen0_mem[wr_ptr]  <= wen0_i;
            rd0_mem[wr_ptr]   <= rd0_i;
            data0_mem[wr_ptr] <= data0_i;
            wen1_mem[wr_ptr]  <= wen1_i;
            rd1_mem[wr_ptr]   <= rd1_i;
            data1_mem[wr_ptr] <= data1_i;
        end
    end

    // pointers wrap on their own as the depth is a power of two
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            count           <= '0;
            credit_return_o <= 1'b0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count           <= count + (PTR_W+1)'(push_i) - (PTR_W+1)'(pop_i);
            credit_return_o <= pop_i;
        end
    end

    assign not_empty_o  = (count != '0);
    assign head_wen0_o  = wen0_mem[rd_ptr];
    assign head_rd0_o   = rd0_mem[rd_ptr];
    assign head_data0_o = data0_mem[rd_ptr];
    assign head_wen1_o  = wen1_mem[rd_ptr];
    assign head_rd1_o   = rd1_mem[rd_ptr];
    assign head_data1_o = data1_mem[rd_ptr];

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module execute_stage
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,

    input  logic      issue_valid_i,
    output logic      issue_ready_o,
    input  alu_op_e   op0_i,
    input  data_t     a0_i,
    input  data_t     b0_i,
    input  reg_addr_t rd0_i,
    input  logic      wen0_i,
    input  data_t     pc0_i,
    input  data_t     imm0_i,
    input  alu_op_e   op1_i,
    input  data_t     a1_i,
    input  data_t     b1_i,
    input  reg_addr_t rd1_i,
    input  logic      wen1_i,

    input  logic      credit_return_i,
    output logic      push_valid_o,
    output logic      push_wen0_o,
    output reg_addr_t push_rd0_o,
    output data_t     push_data0_o,
    output logic      push_wen1_o,
    output reg_addr_t push_rd1_o,
    output data_t     push_data1_o,

    output logic      branch_valid_o,
    output data_t     branch_target_o
);

    localparam int CREDIT_W = $clog2(`EX_FIFO_DEPTH) + 1;

    logic [CREDIT_W-1:0] credit_cnt;
    logic                accept;
    data_t               result0;
    data_t               result1;
    logic                is_branch0;
    logic                is_branch1;
    logic                taken0;
    data_t               target0;
    logic                lane_wen0;
    logic                lane_wen1;

    alu_lane #(.HAS_BRANCH(1'b1)) u_main_lane (
        .op_i       (op0_i),
        .a_i        (a0_i),
        .b_i        (b0_i),
        .pc_i       (pc0_i),
        .imm_i      (imm0_i),
        .result_o   (result0),
        .is_branch_o(is_branch0),
        .taken_o    (taken0),
        .target_o   (target0)
    );

    // pc and imm are only meaningful on the main lane
    alu_lane #(.HAS_BRANCH(1'b0)) u_deputy_lane (
        .op_i       (op1_i),
        .a_i        (a1_i),
        .b_i        (b1_i),
        .pc_i       (pc0_i),
        .imm_i      (imm0_i),
        .result_o   (result1),
        .is_branch_o(is_branch1),
        .taken_o    (),
        .target_o   ()
    );

    assign issue_ready_o = (credit_cnt != '0);
    assign accept        = issue_valid_i && issue_ready_o;

    // a taken main branch squashes the deputy write
    assign lane_wen0 = wen0_i && !is_branch0;
    assign lane_wen1 = wen1_i && !is_branch1 && !taken0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_cnt <= CREDIT_W'(`EX_FIFO_DEPTH);
        end else if (accept && !credit_return_i) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!accept && credit_return_i) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            push_valid_o   <= 1'b0;
            branch_valid_o <= 1'b0;
        end else begin
            push_valid_o   <= accept;
            branch_valid_o <= accept && taken0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            push_wen0_o     <= lane_wen0;
            push_rd0_o      <= rd0_i;
            push_data0_o    <= result0;
            push_wen1_o     <= lane_wen1;
            push_rd1_o      <= rd1_i;
            push_data1_o    <= result1;
            branch_target_o <= target0;
        end
    end

endmodule

`default_nettype wire

/* rtl/alu_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_lane
    import ex_pkg::*;
#(
    parameter bit HAS_BRANCH = 1'b1
) (
    input  alu_op_e op_i,
    input  data_t   a_i,
    input  data_t   b_i,
    input  data_t   pc_i,
    input  data_t   imm_i,
    output data_t   result_o,
    output logic    is_branch_o,
    output logic    taken_o,
    output data_t   target_o
);

    always_comb begin
        result_o    = '0;
        is_branch_o = 1'b0;
        case (op_i)
            OP_ADD: result_o = a_i + b_i;
            OP_SUB: result_o = a_i - b_i;
            OP_AND: result_o = a_i & b_i;
            OP_OR:  result_o = a_i | b_i;
            OP_XOR: result_o = a_i ^ b_i;
            // shift amount from low five bits of b
            OP_SLL: result_o = a_i << b_i[4:0];
            OP_SRL: result_o = a_i >> b_i[4:0];
            OP_BEQ: is_branch_o = 1'b1;
            OP_BNE: is_branch_o = 1'b1;
            default: result_o = '0;
        endcase
    end

    generate
        if (HAS_BRANCH) begin : g_branch
            assign taken_o = ((op_i == OP_BEQ) && (a_i == b_i))
                          || ((op_i == OP_BNE) && (a_i != b_i));
            assign target_o = pc_i + imm_i;
        end else begin : g_no_branch
            // deputy lane never redirects
            assign taken_o  = 1'b0;
            assign target_o = '0;
        end
    endgenerate

endmodule

`default_nettype wire

/* rtl/ex_pkg.sv */
`default_nettype none

package ex_pkg;

    `include "ex_settings.svh"

    typedef logic [`EX_DATA_W-1:0] data_t;
    typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        // branches write no register
        OP_BEQ,
        OP_BNE
    } alu_op_e;

    // progress through the held pair
    typedef enum logic [1:0] {
        WB_EMPTY,
        WB_LANE0,
        WB_LANE1
    } wb_state_e;

endpackage

`default_nettype wire

/* rtl/ex_settings.svh */
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// operand and result width
`define EX_DATA_W 32

// destination register number width
`define EX_REG_ADDR_W 5

// result pairs in the buffer and the initial credit count
// a power of two of at least 2
`define EX_FIFO_DEPTH 4

`endif
